// File: tests/hazard_vectors.txt
# name rs rt rd regWrite memRead branch iCacheOk dCacheOk memFlush, then expected:
# exRsSel exRtSel idRsSel idRtSel enables(pc pfIf ifId idEx exMem1 mem1Mem2 mem2Wb) isStall
reset_idle    1  2  3  0 0 0 1 1 0  0 0 0 0 1111111 0
alu_chain     1  2  5  1 0 0 1 1 0  0 0 0 0 1111111 0
alu_chain     1  2  5  1 0 0 1 1 0  0 0 0 0 1111111 0
alu_chain     1  2  5  1 0 0 1 1 0  0 0 0 0 1111111 0
alu_chain     5  5  6  1 0 0 1 1 0  1 1 2 2 1111111 0
alu_chain     5  7  0  0 0 0 1 1 0  2 0 2 0 1111111 0
alu_chain     5  6  0  0 0 0 1 1 0  3 2 3 2 1111111 0
alu_chain     5  6  0  0 0 0 1 1 0  0 3 1 3 1111111 0
alu_chain     6  5  0  0 0 0 1 1 0  0 0 1 0 1111111 0
load_use      1  2  8  1 1 0 1 1 0  0 0 0 0 1111111 0
load_use      8  3  9  1 0 0 1 1 0  1 0 0 0 0001111 1
load_use      8  3  9  1 0 0 1 1 0  2 0 2 0 0001111 1
load_use      8  3  9  1 0 0 1 1 0  3 0 3 0 1111111 0
load_gap      1  2 10  1 1 0 1 1 0  0 0 0 0 1111111 0
load_gap      1  2 11  0 0 0 1 1 0  0 0 0 0 1111111 0
load_gap      3 10 12  1 0 0 1 1 0  0 2 0 2 0001111 1
load_gap      3 10 12  1 0 0 1 1 0  0 3 0 3 1111111 0
cache_freeze 12 10  0  0 0 0 1 0 0  1 0 0 1 0000000 1
cache_freeze 12 10  0  0 0 0 0 1 0  1 0 0 1 0000000 1
cache_freeze 12 10  0  0 0 0 1 1 0  1 0 0 1 1111111 0
flush         1  2 13  1 0 0 1 1 0  0 0 0 0 1111111 0
flush         1  2 14  1 0 0 1 1 0  0 0 0 0 1111111 0
flush        13 14  0  0 0 0 1 0 1  2 1 2 0 1111100 1
flush        13 12  0  0 0 0 1 1 0  0 0 0 1 1111111 0
flush        13 14  0  0 0 0 1 1 0  0 0 0 0 1111111 0
reg_zero      0  0  0  1 1 0 1 1 0  0 0 0 0 1111111 0
reg_zero      0  0  0  1 0 1 1 1 0  0 0 0 0 1111111 0
reg_zero      0  0 15  0 0 1 1 1 0  0 0 0 0 1111111 0
reg_zero      0  0  0  0 0 1 1 1 0  0 0 0 0 1111111 0
branch_hazard 1  2 16  1 0 0 1 1 0  0 0 0 0 1111111 0
branch_hazard 16 0  0  0 0 1 1 1 0  1 0 0 0 0001111 1
branch_hazard 16 0  0  0 0 1 1 1 0  2 0 2 0 1111111 0

// File: hazardUnit.f
+incdir+design
design/hazardPkg.sv
design/stageTracker.sv
design/forwardSelect.sv
design/stallControl.sv
design/hazardUnit.sv
tests/hazardChecker.sv
tests/hazardUnitTb.sv

// File: tests/hazardUnitTb.sv
`timescale 1ns/1ps

// Vector driven testbench for the hazard control unit
module hazardUnitTb;

	localparam int resetCycles = 3;
	localparam int nameW = 128; // Test names up to 16 characters

	logic              clk;
	logic              arstN;
	hazardPkg::regIdxT idRs;
	hazardPkg::regIdxT idRt;
	hazardPkg::regIdxT idRd;
	logic              idRegWrite;
	logic              idMemRead;
	logic              idBranch;
	logic              iCacheDataOk;
	logic              dCacheDataOk;
	logic              memFlush;
	hazardPkg::fwdSelT exRsSel;
	hazardPkg::fwdSelT exRtSel;
	hazardPkg::fwdSelT idRsSel;
	hazardPkg::fwdSelT idRtSel;
	logic              pcWr;
	logic              pfIfWr;
	logic              ifIdWr;
	logic              idExWr;
	logic              exMem1Wr;
	logic              mem1Mem2Wr;
	logic              mem2WbWr;
	logic              isStall;

	logic              checkEn;
	logic              runDone;
	logic [nameW-1:0]  testName;
	logic [15:0]       expected;
	logic              reportDone;
	int                errorCount;
	int                checkCount;

	logic [nameW-1:0]  nameQ[$];
	logic [20:0]       stimQ[$]; // ID fields, cache levels and flush
	logic [15:0]       expQ[$]; // Selects, enables and isStall
	bit                loadError;
	int                cycleCount;
	int                cycleLimit;

	hazardUnit dut_i (.*);

	hazardChecker #(.nameW(nameW)) check_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// Loads every vector line into the stimulus and expectation queues
	task automatic readVectors();
		int               fd;
		int               cnt;
		int               lineNo;
		string            line;
		logic [nameW-1:0] name;
		int               f[15];
		lineNo = 0;
		fd = $fopen("tests/hazard_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file tests/hazard_vectors.txt");
			loadError = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				lineNo++;
				if (cnt > 0 && line.getc(0) != "#") begin
					cnt = $sscanf(line, "%s %d %d %d %b %b %b %b %b %b %d %d %d %d %b %b",
						name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
						f[9], f[10], f[11], f[12], f[13], f[14]);
					if (cnt == 16) begin
						nameQ.push_back(name);
						stimQ.push_back({f[0][4:0], f[1][4:0], f[2][4:0], f[3][0], f[4][0],
							f[5][0], f[6][0], f[7][0], f[8][0]});
						expQ.push_back({f[9][1:0], f[10][1:0], f[11][1:0], f[12][1:0],
							f[13][6:0], f[14][0]});
					end else if (cnt > 0) begin
						$display("Vector file line %0d has %0d fields instead of 16", lineNo, cnt);
						loadError = 1'b1;
					end
				end
			end
			$fclose(fd);
			if (stimQ.size() == 0) begin
				$display("The vector file holds no vectors");
				loadError = 1'b1;
			end
		end
	endtask

	task automatic applyVector(input int idx);
		{idRs, idRt, idRd, idRegWrite, idMemRead, idBranch,
			iCacheDataOk, dCacheDataOk, memFlush} = stimQ[idx];
		testName = nameQ[idx];
		expected = expQ[idx];
		checkEn  = 1'b1;
	endtask

	// Hard limit on run length, derived from the vector count
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles, the run did not reach its end", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		arstN = 1'b0;
		{idRs, idRt, idRd, idRegWrite, idMemRead, idBranch,
			iCacheDataOk, dCacheDataOk, memFlush} = {15'd0, 3'b000, 3'b110}; // Caches ready
		checkEn    = 1'b0;
		runDone    = 1'b0;
		testName   = '0;
		expected   = '0;
		loadError  = 1'b0;
		cycleCount = 0;
		readVectors();
		cycleLimit = stimQ.size() + resetCycles + 20;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		if (!loadError) begin
			for (i = 0; i < stimQ.size(); i++) begin
				applyVector(i);
				@(negedge clk); // Checked at the rising edge in between
			end
		end
		checkEn = 1'b0;
		runDone = 1'b1;
		wait (reportDone);
		if (!loadError && errorCount == 0 && checkCount == stimQ.size()) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: tests/hazardChecker.sv
`timescale 1ns/1ps

// Compares DUT outputs with the expected values of each vector and keeps the tally
module hazardChecker #(
	parameter int nameW = 128
) (
	input  logic              clk,
	input  logic              checkEn,
	input  logic              runDone,
	input  logic [nameW-1:0]  testName,
	input  logic [15:0]       expected,
	input  hazardPkg::fwdSelT exRsSel,
	input  hazardPkg::fwdSelT exRtSel,
	input  hazardPkg::fwdSelT idRsSel,
	input  hazardPkg::fwdSelT idRtSel,
	input  logic              pcWr,
	input  logic              pfIfWr,
	input  logic              ifIdWr,
	input  logic              idExWr,
	input  logic              exMem1Wr,
	input  logic              mem1Mem2Wr,
	input  logic              mem2WbWr,
	input  logic              isStall,
	output logic              reportDone,
	output int                errorCount,
	output int                checkCount
);

	logic [nameW-1:0] curName = '0;
	int               curErrors = 0;
	int               curCycles = 0;
	int               testsPassed = 0;
	int               testsFailed = 0;
	int               mismatches = 0;
	int               checks = 0;
	logic             done = 1'b0;

	assign reportDone = done;
	assign errorCount = mismatches;
	assign checkCount = checks;

	task automatic compareField(input string sigName, input logic [6:0] expVal,
		input logic [6:0] actVal);
		if (actVal !== expVal) begin
			$display("[FAIL] %0s vector %0d %0s expected %0d actual %0d",
				curName, checks, sigName, expVal, actVal);
			curErrors++;
			mismatches++;
		end
	endtask

	// One summary line when a test's last vector has been checked
	task automatic finishTest();
		if (curErrors == 0) begin
			$display("[PASS] %0s over %0d cycles", curName, curCycles);
			testsPassed++;
		end else begin
			$display("Test %0s had %0d mismatches over %0d cycles", curName, curErrors, curCycles);
			testsFailed++;
		end
		curErrors = 0;
		curCycles = 0;
	endtask

	// Outputs are still those of the ending cycle here, tracker updates come later
	always @(posedge clk) begin
		if (checkEn) begin
			if (testName != curName) begin
				if (curName != '0) begin
					finishTest();
				end
				curName = testName;
			end
			checks++;
			curCycles++;
			compareField("exRsSel", expected[15:14], exRsSel);
			compareField("exRtSel", expected[13:12], exRtSel);
			compareField("idRsSel", expected[11:10], idRsSel);
			compareField("idRtSel", expected[9:8], idRtSel);
			compareField("pcWr", expected[7], pcWr);
			compareField("pfIfWr", expected[6], pfIfWr);
			compareField("ifIdWr", expected[5], ifIdWr);
			compareField("idExWr", expected[4], idExWr);
			compareField("exMem1Wr", expected[3], exMem1Wr);
			compareField("mem1Mem2Wr", expected[2], mem1Mem2Wr);
			compareField("mem2WbWr", expected[1], mem2WbWr);
			compareField("isStall", expected[0], isStall);
		end else if (runDone && !done) begin
			if (curName != '0) begin
				finishTest();
			end
			$display("Tests passed %0d, tests failed %0d, vectors checked %0d, mismatches %0d",
				testsPassed, testsFailed, checks, mismatches);
			done = 1'b1;
		end
	end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps

// Hazard control for the seven-stage pipeline
module hazardUnit (
	input  logic              clk,
	input  logic              arstN,
	input  hazardPkg::regIdxT idRs,
	input  hazardPkg::regIdxT idRt,
	input  hazardPkg::regIdxT idRd,
	input  logic              idRegWrite,
	input  logic              idMemRead,
	input  logic              idBranch,
	input  logic              iCacheDataOk,
	input  logic              dCacheDataOk,
	input  logic              memFlush,
	output hazardPkg::fwdSelT exRsSel,
	output hazardPkg::fwdSelT exRtSel,
	output hazardPkg::fwdSelT idRsSel,
	output hazardPkg::fwdSelT idRtSel,
	output logic              pcWr,
	output logic              pfIfWr,
	output logic              ifIdWr,
	output logic              idExWr,
	output logic              exMem1Wr,
	output logic              mem1Mem2Wr,
	output logic              mem2WbWr,
	output logic              isStall
);

	hazardPkg::regIdxT exRd;
	hazardPkg::regIdxT mem1Rd;
	hazardPkg::regIdxT mem2Rd;
	hazardPkg::regIdxT wbRd;
	logic              exRegWrite;
	logic              mem1RegWrite;
	logic              mem2RegWrite;
	logic              wbRegWrite;
	logic              exMemRead;
	logic              mem1MemRead;
	logic              mem2MemRead;

	stageTracker tracker_i (
		.clk          (clk),
		.arstN        (arstN),
		.idRd         (idRd),
		.idRegWrite   (idRegWrite),
		.idMemRead    (idMemRead),
		.memFlush     (memFlush),
		.ifIdWr       (ifIdWr),
		.idExWr       (idExWr),
		.exMem1Wr     (exMem1Wr),
		.mem1Mem2Wr   (mem1Mem2Wr),
		.mem2WbWr     (mem2WbWr),
		.exRd         (exRd),
		.mem1Rd       (mem1Rd),
		.mem2Rd       (mem2Rd),
		.wbRd         (wbRd),
		.exRegWrite   (exRegWrite),
		.mem1RegWrite (mem1RegWrite),
		.mem2RegWrite (mem2RegWrite),
		.wbRegWrite   (wbRegWrite),
		.exMemRead    (exMemRead),
		.mem1MemRead  (mem1MemRead),
		.mem2MemRead  (mem2MemRead)
	);

	forwardSelect bypass_i (
		.idRs         (idRs),
		.idRt         (idRt),
		.exRd         (exRd),
		.mem1Rd       (mem1Rd),
		.mem2Rd       (mem2Rd),
		.wbRd         (wbRd),
		.exRegWrite   (exRegWrite),
		.mem1RegWrite (mem1RegWrite),
		.mem2RegWrite (mem2RegWrite),
		.wbRegWrite   (wbRegWrite),
		.exRsSel      (exRsSel),
		.exRtSel      (exRtSel),
		.idRsSel      (idRsSel),
		.idRtSel      (idRtSel)
	);

	stallControl stall_i (
		.idRs         (idRs),
		.idRt         (idRt),
		.idBranch     (idBranch),
		.exRd         (exRd),
		.mem1Rd       (mem1Rd),
		.mem2Rd       (mem2Rd),
		.exRegWrite   (exRegWrite),
		.mem1RegWrite (mem1RegWrite),
		.mem2RegWrite (mem2RegWrite),
		.exMemRead    (exMemRead),
		.mem1MemRead  (mem1MemRead),
		.mem2MemRead  (mem2MemRead),
		.iCacheDataOk (iCacheDataOk),
		.dCacheDataOk (dCacheDataOk),
		.memFlush     (memFlush),
		.pcWr         (pcWr),
		.pfIfWr       (pfIfWr),
		.ifIdWr       (ifIdWr),
		.idExWr       (idExWr),
		.exMem1Wr     (exMem1Wr),
		.mem1Mem2Wr   (mem1Mem2Wr),
		.mem2WbWr     (mem2WbWr),
		.isStall      (isStall)
	);

endmodule

// File: design/stallControl.sv
`timescale 1ns/1ps

// Load-use and branch hazard detection plus per-stage write enables
module stallControl (
	input  hazardPkg::regIdxT idRs,
	input  hazardPkg::regIdxT idRt,
	input  logic              idBranch,
	input  hazardPkg::regIdxT exRd,
	input  hazardPkg::regIdxT mem1Rd,
	input  hazardPkg::regIdxT mem2Rd,
	input  logic              exRegWrite,
	input  logic              mem1RegWrite,
	input  logic              mem2RegWrite,
	input  logic              exMemRead,
	input  logic              mem1MemRead,
	input  logic              mem2MemRead,
	input  logic              iCacheDataOk,
	input  logic              dCacheDataOk,
	input  logic              memFlush,
	output logic              pcWr,
	output logic              pfIfWr,
	output logic              ifIdWr,
	output logic              idExWr,
	output logic              exMem1Wr,
	output logic              mem1Mem2Wr,
	output logic              mem2WbWr,
	output logic              isStall
);

	logic exHit;
	logic mem1Hit;
	logic mem2Hit;
	logic exStall;
	logic mem1Stall;
	logic mem2Stall;
	logic dataStall;
	logic wholeStall;

	// A stage hits when it writes a register the ID instruction reads
	assign exHit   = exRegWrite & ((exRd == idRs) | (exRd == idRt));
	assign mem1Hit = mem1RegWrite & ((mem1Rd == idRs) | (mem1Rd == idRt));
	assign mem2Hit = mem2RegWrite & ((mem2Rd == idRs) | (mem2Rd == idRt));

	assign exStall   = exHit & (exMemRead | idBranch); // Branch compares in ID
	assign mem1Stall = mem1Hit & mem1MemRead; // Load data not back yet
	assign mem2Stall = mem2Hit & mem2MemRead & idBranch; // Too late for branch compare

	assign dataStall  = exStall | mem1Stall | mem2Stall;
	assign wholeStall = ~iCacheDataOk | ~dCacheDataOk; // Either cache busy
	assign isStall    = wholeStall | dataStall;

	always_comb begin
		if (memFlush) begin
			// Redirect front end, drain the back end once data is ready
			pcWr       = 1'b1;
			pfIfWr     = 1'b1;
			ifIdWr     = 1'b1;
			idExWr     = 1'b1;
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = dCacheDataOk;
			mem2WbWr   = dCacheDataOk;
		end else if (wholeStall) begin
			pcWr       = 1'b0; // Freeze everything
			pfIfWr     = 1'b0;
			ifIdWr     = 1'b0;
			idExWr     = 1'b0;
			exMem1Wr   = 1'b0;
			mem1Mem2Wr = 1'b0;
			mem2WbWr   = 1'b0;
		end else if (dataStall) begin
			pcWr       = 1'b0; // Hold PC through ID
			pfIfWr     = 1'b0;
			ifIdWr     = 1'b0;
			idExWr     = 1'b1; // Bubble goes into EX
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = 1'b1;
			mem2WbWr   = 1'b1;
		end else begin
			pcWr       = 1'b1;
			pfIfWr     = 1'b1;
			ifIdWr     = 1'b1;
			idExWr     = 1'b1;
			exMem1Wr   = 1'b1;
			mem1Mem2Wr = 1'b1;
			mem2WbWr   = 1'b1;
		end
	end

endmodule

// File: design/forwardSelect.sv
`timescale 1ns/1ps
`include "hazard_cfg.svh"

// Bypass multiplexer selects for the ID read port and the EX operand port
module forwardSelect (
	input  hazardPkg::regIdxT idRs,
	input  hazardPkg::regIdxT idRt,
	input  hazardPkg::regIdxT exRd,
	input  hazardPkg::regIdxT mem1Rd,
	input  hazardPkg::regIdxT mem2Rd,
	input  hazardPkg::regIdxT wbRd,
	input  logic              exRegWrite,
	input  logic              mem1RegWrite,
	input  logic              mem2RegWrite,
	input  logic              wbRegWrite,
	output hazardPkg::fwdSelT exRsSel,
	output hazardPkg::fwdSelT exRtSel,
	output hazardPkg::fwdSelT idRsSel,
	output hazardPkg::fwdSelT idRtSel
);

	// Youngest writer wins, EX before MEM1 before MEM2
	function automatic hazardPkg::fwdSelT exOperandSel(input hazardPkg::regIdxT src);
		hazardPkg::fwdSelT sel;
		if (exRegWrite && (exRd == src)) begin
			sel = `FWD_NEAR; // EX result
		end else if (mem1RegWrite && (mem1Rd == src)) begin
			sel = `FWD_MID; // MEM1 result
		end else if (mem2RegWrite && (mem2Rd == src)) begin
			sel = `FWD_FAR; // MEM2 result
		end else begin
			sel = `FWD_NONE;
		end
		return sel;
	endfunction

	// An EX producer stalls ID instead, so the search starts at MEM1
	function automatic hazardPkg::fwdSelT idReadSel(input hazardPkg::regIdxT src);
		hazardPkg::fwdSelT sel;
		if (mem1RegWrite && (mem1Rd == src)) begin
			sel = `FWD_MID; // MEM1 into ID
		end else if (mem2RegWrite && (mem2Rd == src)) begin
			sel = `FWD_FAR; // MEM2 into ID
		end else if (wbRegWrite && (wbRd == src)) begin
			sel = `FWD_NEAR; // WB into ID
		end else begin
			sel = `FWD_NONE;
		end
		return sel;
	endfunction

	always_comb begin
		exRsSel = exOperandSel(idRs);
		exRtSel = exOperandSel(idRt);
	end

	always_comb begin
		idRsSel = idReadSel(idRs);
		idRtSel = idReadSel(idRt);
	end

endmodule

// File: design/stageTracker.sv
`timescale 1ns/1ps
`include "hazard_cfg.svh"

// Write-back descriptors of the instructions in EX, MEM1, MEM2 and WB
module stageTracker (
	input  logic              clk,
	input  logic              arstN,
	input  hazardPkg::regIdxT idRd,
	input  logic              idRegWrite,
	input  logic              idMemRead,
	input  logic              memFlush,
	input  logic              ifIdWr,
	input  logic              idExWr,
	input  logic              exMem1Wr,
	input  logic              mem1Mem2Wr,
	input  logic              mem2WbWr,
	output hazardPkg::regIdxT exRd,
	output hazardPkg::regIdxT mem1Rd,
	output hazardPkg::regIdxT mem2Rd,
	output hazardPkg::regIdxT wbRd,
	output logic              exRegWrite,
	output logic              mem1RegWrite,
	output logic              mem2RegWrite,
	output logic              wbRegWrite,
	output logic              exMemRead,
	output logic              mem1MemRead,
	output logic              mem2MemRead
);

	logic idWritesReg;

	// A write to r0 is architecturally a no-op, so it never enters as a writer
	assign idWritesReg = idRegWrite & (idRd != `REG_ZERO);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
		end else if (memFlush) begin
			exRegWrite <= 1'b0; // Squashed by MEM1 exception
			exMemRead  <= 1'b0;
		end else if (idExWr) begin
			if (ifIdWr) begin
				exRegWrite <= idWritesReg;
				exMemRead  <= idMemRead;
			end else begin
				exRegWrite <= 1'b0; // ID held, bubble into EX
				exMemRead  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mem1RegWrite <= 1'b0;
			mem1MemRead  <= 1'b0;
		end else if (memFlush) begin
			mem1RegWrite <= 1'b0; // Faulting instruction dropped
			mem1MemRead  <= 1'b0;
		end else if (exMem1Wr) begin
			mem1RegWrite <= exRegWrite;
			mem1MemRead  <= exMemRead;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mem2RegWrite <= 1'b0;
			mem2MemRead  <= 1'b0;
		end else if (mem1Mem2Wr) begin
			mem2RegWrite <= mem1RegWrite;
			mem2MemRead  <= mem1MemRead;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbRegWrite <= 1'b0;
		end else if (mem2WbWr) begin
			wbRegWrite <= mem2RegWrite;
		end
	end

	// Destination indices only matter while the matching write flag is set
	always_ff @(posedge clk) begin
		if (idExWr) begin
			exRd <= idRd;
		end
		if (exMem1Wr) begin
			mem1Rd <= exRd;
		end
		if (mem1Mem2Wr) begin
			mem2Rd <= mem1Rd;
		end
		if (mem2WbWr) begin
			wbRd <= mem2Rd;
		end
	end

endmodule

// File: design/hazardPkg.sv
`include "hazard_cfg.svh"

// Types shared by the hazard control blocks and the testbench
package hazardPkg;

	// Architectural register number
	typedef logic [`REG_IDX_W-1:0] regIdxT;

	// Select code for one bypass multiplexer
	typedef logic [`FWD_SEL_W-1:0] fwdSelT;

endpackage

// File: design/hazard_cfg.svh
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// Register file addressing
`define REG_IDX_W 5 // 32 architectural registers
`define REG_ZERO  5'd0 // Hardwired zero register

// Bypass select encoding
`define FWD_SEL_W 2

// EX operand: NEAR is EX result, MID is MEM1, FAR is MEM2
// ID read: NEAR is WB, MID is MEM1, FAR is MEM2
`define FWD_NONE 2'b00 // Register file value
`define FWD_NEAR 2'b01
`define FWD_MID  2'b10
`define FWD_FAR  2'b11

`endif
